// File: logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] addr_t;   // Byte address
    typedef logic [31:0] word_t;   // Memory word

    // One buffered halfword, tagged with the error flag of the word it came from
    typedef struct packed {
        logic        err;
        logic [15:0] half;
    } half_entry_t;

    typedef logic [1:0] depth_t;   // Halfwords held, 0 to 3

    // Low bits of a 32-bit instruction
    localparam logic [1:0] len32_code = 2'b11;

    localparam depth_t depth_full = 2'd3;   // Buffer capacity in halfwords
    localparam addr_t  word_step  = 32'd4;  // Sequential fetch stride

endpackage

`default_nettype wire

// File: logic/fetch_rsp_if.sv
`timescale 1ns/1ps
`default_nettype none

// Accepted memory responses on their way to the fetch buffer
interface fetch_rsp_if import fetch_pkg::*; ();

    logic  rsp_4byte;   // Whole word valid
    logic  rsp_2byte;   // Only the upper halfword is wanted
    logic  rsp_err;     // Bus error on this word
    word_t rsp_data;
    logic  rsp_ready;   // Buffer takes the word this cycle

    modport source (
        output rsp_4byte,
        output rsp_2byte,
        output rsp_err,
        output rsp_data,
        input  rsp_ready
    );

    modport sink (
        input  rsp_4byte,
        input  rsp_2byte,
        input  rsp_err,
        input  rsp_data,
        output rsp_ready
    );

endinterface

`default_nettype wire

// File: logic/fetch_request.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_request import fetch_pkg::*; #(
    parameter addr_t       reset_pc        = 32'h0000_0000,
    parameter int unsigned max_outstanding = 2
) (
    input  logic        g_clk,
    input  logic        arst_n,

    input  logic        redirect_valid,
    input  addr_t       redirect_pc,

    output logic        mem_req_valid,
    output addr_t       mem_req_addr,
    input  logic        mem_req_ready,

    input  logic        mem_rsp_valid,
    input  word_t       mem_rsp_data,
    input  logic        mem_rsp_err,
    output logic        mem_rsp_ready,

    fetch_rsp_if.source rsp
);

    localparam int cnt_w = $clog2(max_outstanding + 1);

    typedef logic [cnt_w-1:0] cnt_t;

    localparam cnt_t max_cnt = cnt_t'(max_outstanding);

    addr_t next_addr;   // Word address of the next read
    cnt_t  out_cnt;     // Reads issued and not yet answered
    cnt_t  out_cnt_n;
    cnt_t  stale_cnt;   // Answers still owed to the old path
    logic  run;         // Held low until the first cycle out of reset
    logic  half_pend;   // Next forwarded word starts at its upper half
    logic  req_fire;
    logic  rsp_fire;
    logic  fwd;

    assign mem_req_valid = run && (out_cnt < max_cnt);
    assign mem_req_addr  = next_addr;
    assign req_fire      = mem_req_valid && mem_req_ready;

    // A word arriving with a redirect belongs to the old path as well
    assign fwd = mem_rsp_valid && (out_cnt != '0) && (stale_cnt == '0) && !redirect_valid;

    // Stale words are swallowed without waiting on the buffer
    assign mem_rsp_ready = (out_cnt != '0) &&
                           ((stale_cnt != '0) || redirect_valid || rsp.rsp_ready);
    assign rsp_fire      = mem_rsp_valid && mem_rsp_ready;

    assign out_cnt_n = out_cnt + cnt_t'(req_fire) - cnt_t'(rsp_fire);

    assign rsp.rsp_4byte = fwd && !half_pend;
    assign rsp.rsp_2byte = fwd &&  half_pend;
    assign rsp.rsp_err   = mem_rsp_err;
    assign rsp.rsp_data  = mem_rsp_data;

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            run       <= 1'b0;
            next_addr <= {reset_pc[31:2], 2'b00};
            out_cnt   <= '0;
            stale_cnt <= '0;
            half_pend <= reset_pc[1];
        end else begin
            run     <= 1'b1;
            out_cnt <= out_cnt_n;
            if (redirect_valid) begin
                // An unaccepted request to the old path is abandoned here
                next_addr <= {redirect_pc[31:2], 2'b00};
                stale_cnt <= out_cnt_n;        // Everything in flight is now stale
                half_pend <= redirect_pc[1];   // Odd halfword target
            end else begin
                if (req_fire) begin
                    next_addr <= next_addr + word_step;
                end
                if (rsp_fire && (stale_cnt != '0)) begin
                    stale_cnt <= stale_cnt - cnt_t'(1);
                end
                if (rsp_fire && fwd) begin
                    half_pend <= 1'b0;   // Only the first word after the jump
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer import fetch_pkg::*; (
    input  logic        g_clk,
    input  logic        arst_n,
    input  logic        flush,

    fetch_rsp_if.sink   rsp,

    output depth_t      buf_depth,
    output half_entry_t buf_lo,
    output half_entry_t buf_hi,
    output logic        buf_valid,
    output logic        buf_len4,
    input  logic        buf_ready
);

    half_entry_t slot   [3];   // Slot 0 is the oldest halfword
    half_entry_t slot_n [3];
    depth_t      depth;
    depth_t      depth_n;
    half_entry_t in_lo;
    half_entry_t in_hi;
    logic        load4;
    logic        load2;
    logic        show_2;       // 16-bit instruction ready at the head
    logic        show_4;       // 32-bit instruction ready at the head
    logic        eat_2;
    logic        eat_4;

    assign in_lo = {rsp.rsp_err, rsp.rsp_data[15:0]};
    assign in_hi = {rsp.rsp_err, rsp.rsp_data[31:16]};

    assign load4 = rsp.rsp_4byte && rsp.rsp_ready;
    assign load2 = rsp.rsp_2byte && rsp.rsp_ready;

    assign buf_len4 = slot[0].half[1:0] == len32_code;
    assign show_2   = (depth != '0) && !buf_len4;
    assign show_4   = (depth >= 2'd2) && buf_len4;
    assign eat_2    = show_2 && buf_ready;
    assign eat_4    = show_4 && buf_ready;

    assign buf_valid = show_2 || show_4;
    assign buf_depth = depth;
    assign buf_lo    = slot[0];
    assign buf_hi    = slot[1];

    // Room for a whole word after this cycle's consume
    assign rsp.rsp_ready = (depth < 2'd2) ||
                           ((depth == 2'd2) && (eat_2 || eat_4)) ||
                           ((depth == depth_full) && eat_4);

    always_comb begin
        slot_n  = slot;   // Hold by default
        depth_n = depth;

        case (depth)
            2'd0: begin
                if (load4) begin
                    slot_n[0] = in_lo;
                    slot_n[1] = in_hi;
                    depth_n   = 2'd2;
                end else if (load2) begin   // Only right after a flush
                    slot_n[0] = in_hi;
                    depth_n   = 2'd1;
                end
            end
            2'd1: begin
                if (load4 && eat_2) begin
                    slot_n[0] = in_lo;
                    slot_n[1] = in_hi;
                    depth_n   = 2'd2;
                end else if (load4) begin   // Top half of a 32-bit instruction arrives
                    slot_n[1] = in_lo;
                    slot_n[2] = in_hi;
                    depth_n   = 2'd3;
                end else if (eat_2) begin
                    depth_n   = 2'd0;
                end
            end
            2'd2: begin
                if (load4 && eat_4) begin
                    slot_n[0] = in_lo;
                    slot_n[1] = in_hi;
                end else if (load4 && eat_2) begin
                    slot_n[0] = slot[1];
                    slot_n[1] = in_lo;
                    slot_n[2] = in_hi;
                    depth_n   = 2'd3;
                end else if (eat_4) begin
                    depth_n   = 2'd0;
                end else if (eat_2) begin
                    slot_n[0] = slot[1];
                    depth_n   = 2'd1;
                end
            end
            2'd3: begin
                if (load4 && eat_4) begin
                    slot_n[0] = slot[2];
                    slot_n[1] = in_lo;
                    slot_n[2] = in_hi;
                end else if (eat_4) begin
                    slot_n[0] = slot[2];
                    depth_n   = 2'd1;
                end else if (eat_2) begin
                    slot_n[0] = slot[1];
                    slot_n[1] = slot[2];
                    depth_n   = 2'd2;
                end
            end
        endcase
    end

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            depth <= '0;
        end else if (flush) begin
            depth <= '0;   // Redirect drops everything held
        end else begin
            depth <= depth_n;
        end
    end

    always_ff @(posedge g_clk) begin
        slot <= slot_n;
    end

endmodule

`default_nettype wire

// File: logic/fetch_issue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_issue import fetch_pkg::*; #(
    parameter addr_t reset_pc = 32'h0000_0000
) (
    input  logic        g_clk,
    input  logic        arst_n,

    input  logic        redirect_valid,
    input  addr_t       redirect_pc,

    input  depth_t      buf_depth,
    input  half_entry_t buf_lo,
    input  half_entry_t buf_hi,
    input  logic        buf_valid,
    input  logic        buf_len4,
    output logic        buf_ready,

    output logic        instr_valid,
    output word_t       instr_data,
    output addr_t       instr_pc,
    output logic        instr_len4,
    output logic        instr_err,
    input  logic        instr_ready
);

    addr_t pc;        // Address of the halfword at the buffer head
    logic  show_lo;   // Head slot holds real data
    logic  show_hi;   // Second slot is part of this instruction
    logic  fire;

    assign show_lo = buf_depth != '0;
    assign show_hi = buf_len4 && (buf_depth >= 2'd2);

    // Handshake ignored while a redirect flushes the buffer
    assign instr_valid = buf_valid && !redirect_valid;
    assign buf_ready   = instr_ready && !redirect_valid;
    assign fire        = instr_valid && instr_ready;

    assign instr_data = {show_hi ? buf_hi.half : 16'h0000,   // Zero for 16-bit
                         show_lo ? buf_lo.half : 16'h0000};
    assign instr_len4 = show_lo && buf_len4;
    assign instr_err  = show_lo && buf_lo.err;   // First halfword decides
    assign instr_pc   = pc;

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_pc;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
        end else if (fire) begin
            pc <= pc + (buf_len4 ? addr_t'(4) : addr_t'(2));
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import fetch_pkg::*; #(
    parameter addr_t       reset_pc        = 32'h0000_0000,
    parameter int unsigned max_outstanding = 2
) (
    input  logic  g_clk,
    input  logic  arst_n,

    output logic  mem_req_valid,
    output addr_t mem_req_addr,
    input  logic  mem_req_ready,

    input  logic  mem_rsp_valid,
    input  word_t mem_rsp_data,
    input  logic  mem_rsp_err,
    output logic  mem_rsp_ready,

    input  logic  redirect_valid,   // Single-cycle pulse
    input  addr_t redirect_pc,

    output logic  instr_valid,
    output word_t instr_data,
    output addr_t instr_pc,
    output logic  instr_len4,
    output logic  instr_err,
    input  logic  instr_ready
);

    depth_t      buf_depth;
    half_entry_t buf_lo;
    half_entry_t buf_hi;
    logic        buf_valid;
    logic        buf_len4;
    logic        buf_ready;

    fetch_rsp_if rsp_if ();

    fetch_request #(
        .reset_pc        (reset_pc),
        .max_outstanding (max_outstanding)
    ) u_request (
        .g_clk          (g_clk),
        .arst_n         (arst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data),
        .mem_rsp_err    (mem_rsp_err),
        .mem_rsp_ready  (mem_rsp_ready),
        .rsp            (rsp_if.source)
    );

    fetch_buffer u_buffer (
        .g_clk     (g_clk),
        .arst_n    (arst_n),
        .flush     (redirect_valid),   // Redirect clears held halfwords
        .rsp       (rsp_if.sink),
        .buf_depth (buf_depth),
        .buf_lo    (buf_lo),
        .buf_hi    (buf_hi),
        .buf_valid (buf_valid),
        .buf_len4  (buf_len4),
        .buf_ready (buf_ready)
    );

    fetch_issue #(
        .reset_pc (reset_pc)
    ) u_issue (
        .g_clk          (g_clk),
        .arst_n         (arst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .buf_depth      (buf_depth),
        .buf_lo         (buf_lo),
        .buf_hi         (buf_hi),
        .buf_valid      (buf_valid),
        .buf_len4       (buf_len4),
        .buf_ready      (buf_ready),
        .instr_valid    (instr_valid),
        .instr_data     (instr_data),
        .instr_pc       (instr_pc),
        .instr_len4     (instr_len4),
        .instr_err      (instr_err),
        .instr_ready    (instr_ready)
    );

endmodule

`default_nettype wire

// File: bench/fetch_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

// Instruction memory that answers in order after a random delay
module fetch_mem_model import fetch_pkg::*; #(
    parameter int max_outstanding = 3,
    parameter int max_latency     = 4
) (
    input  logic  g_clk,
    input  logic  arst_n,
    input  logic  req_valid,
    input  addr_t req_addr,
    output logic  req_ready,
    output logic  rsp_valid,
    output word_t rsp_data,
    output logic  rsp_err,
    input  logic  rsp_ready,
    output logic  limit_err   // Sticky, too many reads in flight
);

    addr_t addr_q [$];   // Accepted reads, oldest first
    int    due_q  [$];   // Earliest cycle for each answer
    int    cyc;
    logic  rsp_done;     // Head answer taken at the coming edge

    // Scrambled word address, so both instruction lengths show up
    function automatic word_t word_at(input addr_t a);
        word_t w;
        w = {a[31:2], 2'b00} * 32'h9e37_79b1;
        return w ^ (w >> 15);
    endfunction

    initial begin
        req_ready = 1'b0;
        rsp_valid = 1'b0;
        rsp_data  = '0;
        rsp_err   = 1'b0;
        limit_err = 1'b0;
        rsp_done  = 1'b0;
        cyc       = 0;
    end

    always begin
        @(negedge g_clk);
        cyc++;
        if (!arst_n) begin
            addr_q.delete();
            due_q.delete();
            req_ready = 1'b0;
            rsp_valid = 1'b0;
        end else begin
            req_ready = ($urandom % 4) != 0;
            if (rsp_done) begin
                rsp_valid = 1'b0;
            end
            // Held until taken
            if (!rsp_valid && (addr_q.size() > 0) && (due_q[0] <= cyc)) begin
                rsp_valid = 1'b1;
                rsp_data  = word_at(addr_q[0]);
                rsp_err   = addr_q[0][7:4] == 4'hA;
            end
        end
        rsp_done = 1'b0;
        #1;   // Values the next rising edge will see
        if (arst_n && rsp_valid && rsp_ready) begin
            void'(addr_q.pop_front());
            void'(due_q.pop_front());
            rsp_done = 1'b1;
        end
        if (arst_n && req_valid && req_ready) begin
            addr_q.push_back(req_addr);
            due_q.push_back(cyc + 1 + int'($urandom % max_latency));
        end
        if (addr_q.size() > max_outstanding) begin
            limit_err = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: bench/fetch_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_tb import fetch_pkg::*; ();

    localparam addr_t reset_pc   = 32'h0000_0100;
    localparam int    max_out    = 3;
    localparam int    clk_period = 20;
    localparam int    num_instr  = 3000;

    logic  g_clk;
    logic  arst_n;
    logic  mem_req_valid;
    addr_t mem_req_addr;
    logic  mem_req_ready;
    logic  mem_rsp_valid;
    word_t mem_rsp_data;
    logic  mem_rsp_err;
    logic  mem_rsp_ready;
    logic  redirect_valid;
    addr_t redirect_pc;
    logic  instr_valid;
    word_t instr_data;
    addr_t instr_pc;
    logic  instr_len4;
    logic  instr_err;
    logic  instr_ready;
    logic  limit_err;

    addr_t model_pc;     // Reference PC of the next expected instruction
    int    cyc;
    int    handshakes;
    logic  first_req_seen;
    logic  prev_valid;
    logic  prev_ready;
    logic  prev_redir;
    word_t prev_data;
    addr_t prev_pc;

    fetch_unit #(.reset_pc(reset_pc), .max_outstanding(max_out)) dut (.*);

    fetch_mem_model #(.max_outstanding(max_out)) mem (
        .g_clk(g_clk), .arst_n(arst_n),
        .req_valid(mem_req_valid), .req_addr(mem_req_addr), .req_ready(mem_req_ready),
        .rsp_valid(mem_rsp_valid), .rsp_data(mem_rsp_data), .rsp_err(mem_rsp_err),
        .rsp_ready(mem_rsp_ready), .limit_err(limit_err)
    );

    // Same image as the memory model
    function automatic word_t word_at(input addr_t a);
        word_t w;
        w = {a[31:2], 2'b00} * 32'h9e37_79b1;
        return w ^ (w >> 15);
    endfunction

    function automatic logic [15:0] half_at(input addr_t a);
        word_t w;
        w = word_at(a);
        return a[1] ? w[31:16] : w[15:0];
    endfunction

    function automatic logic err_at(input addr_t a);
        return a[7:4] == 4'hA;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        stop_run($sformatf("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic drive_inputs();
        if (cyc == 1) begin
            arst_n = 1'b1;   // Low for the first two clock periods
        end
        redirect_valid = 1'b0;
        instr_ready    = ($urandom % 100) < 70;
        if (prev_valid && !prev_ready && (($urandom % 12) == 0)) begin
            redirect_valid = 1'b1;   // Jump taken while the head is offered
            redirect_pc    = ($urandom % 32'h1000) & 32'hffff_fffe;
            instr_ready    = 1'b1;
        end
    endtask

    task automatic check_cycle();
        logic [15:0] h0;
        logic        exp_len4;
        word_t       exp_data;
        if (cyc <= 2) begin
            assert (!instr_valid) else stop_run("instr_valid is high around reset");
            assert (!mem_rsp_ready) else stop_run("mem_rsp_ready is high around reset");
        end
        assert (!limit_err) else stop_run("Memory saw more than three reads without answer");
        if (arst_n && mem_req_valid && mem_req_ready && !first_req_seen) begin
            first_req_seen = 1'b1;
            assert (mem_req_addr == {reset_pc[31:2], 2'b00})
                else mismatch("mem_req_addr", mem_req_addr, {reset_pc[31:2], 2'b00});
        end
        if (prev_redir) begin
            assert (!instr_valid) else stop_run("instr_valid is high right after a redirect");
        end
        if (prev_valid && !prev_ready && !redirect_valid) begin   // Stalled output holds
            assert (instr_valid) else stop_run("instr_valid dropped while stalled");
            assert (instr_pc == prev_pc) else mismatch("instr_pc", instr_pc, prev_pc);
            assert (instr_data == prev_data) else mismatch("instr_data", instr_data, prev_data);
        end
        if (instr_valid && instr_ready) begin
            h0       = half_at(model_pc);
            exp_len4 = h0[1:0] == len32_code;
            exp_data = exp_len4 ? {half_at(model_pc + 32'd2), h0} : {16'h0000, h0};
            assert (instr_pc == model_pc) else mismatch("instr_pc", instr_pc, model_pc);
            assert (instr_data == exp_data) else mismatch("instr_data", instr_data, exp_data);
            assert (instr_len4 == exp_len4)
                else mismatch("instr_len4", 32'(instr_len4), 32'(exp_len4));
            assert (instr_err == err_at(model_pc))
                else mismatch("instr_err", 32'(instr_err), 32'(err_at(model_pc)));
            model_pc = model_pc + (exp_len4 ? 32'd4 : 32'd2);
            handshakes++;
        end
        if (redirect_valid) begin
            model_pc = redirect_pc;
        end
        prev_valid = instr_valid;
        prev_ready = instr_ready;
        prev_redir = redirect_valid;
        prev_data  = instr_data;
        prev_pc    = instr_pc;
    endtask

    initial begin
        g_clk = 1'b0;
        forever #(clk_period / 2) g_clk = ~g_clk;
    end

    initial begin
        #(num_instr * 20 * clk_period);
        stop_run("Timeout, the instruction stream stopped making progress");
    end

    initial begin
        arst_n         = 1'b0;
        instr_ready    = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        model_pc       = reset_pc;
        cyc            = 0;
        handshakes     = 0;
        first_req_seen = 1'b0;
        prev_valid     = 1'b0;
        prev_ready     = 1'b0;
        prev_redir     = 1'b0;
        prev_data      = '0;
        prev_pc        = '0;
        void'($urandom(32'h6ce9_3100));
        while (handshakes < num_instr) begin
            @(negedge g_clk);
            drive_inputs();
            #2;   // Sample before the next rising edge, after the memory model settles
            check_cycle();
            cyc++;
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
logic/fetch_pkg.sv
logic/fetch_rsp_if.sv
logic/fetch_request.sv
logic/fetch_buffer.sv
logic/fetch_issue.sv
logic/fetch_unit.sv
bench/fetch_mem_model.sv
bench/fetch_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the fetch unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f build.f --top-module fetch_unit_tb \
    --Mdir obj_dir -o fetch_sim > build.log 2>&1 \
    && ./obj_dir/fetch_sim > sim.log 2>&1 \
    || echo "Build or simulation exited with an error, see build.log and sim.log"

# The log decides the result
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
